// File: src/qpu_exu_defines.svh
`ifndef QPU_EXU_DEFINES_SVH
`define QPU_EXU_DEFINES_SVH

// Classical datapath
`define QPU_XLEN              32
`define QPU_RFIDX_WIDTH       4   // 16 registers
`define QPU_INSTR_SIZE        32

// Timing and events
`define QPU_TIME_WIDTH        16
`define QPU_EVENT_NUM         8   // Channel mask bits
`define QPU_EVENT_WIRE_WIDTH  16

// Depth of the timing queue and of the event queue
`define QPU_QUEUE_DEPTH       4

`endif

// File: src/qpu_exu_pkg.sv
`include "qpu_exu_defines.svh"

package qpu_exu_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Opcodes, instruction bits 31..28
  typedef enum logic [3:0] {
    OP_ADD   = 4'd1,
    OP_SUB   = 4'd2,
    OP_ADDI  = 4'd3,
    OP_QWAIT = 4'd4,  // Advance the time register
    OP_QEVT  = 4'd5   // Emit an event at the current time point
  } op_e;

  typedef logic [`QPU_TIME_WIDTH-1:0] time_t;

  // One entry of the event queue
  typedef struct packed {
    logic [`QPU_EVENT_NUM-1:0]        mask;
    logic [`QPU_EVENT_WIRE_WIDTH-1:0] data;
  } event_t;

  ////////////////////////////////////////////////////////////////////////////
  // Decoded instruction, decode to exec
  typedef struct packed {
    op_e                         op;
    logic [`QPU_RFIDX_WIDTH-1:0] rd;
    logic [`QPU_RFIDX_WIDTH-1:0] rs1;
    logic [`QPU_RFIDX_WIDTH-1:0] rs2;
    logic [`QPU_XLEN-1:0]        imm;       // Already extended
    logic                        is_alu;    // ADD, SUB, ADDI
    logic                        is_qwait;
    logic                        is_qevt;
  } dec_info_t;

endpackage

// File: src/qpu_exu_decode.sv
`timescale 1ns/100ps

`include "qpu_exu_defines.svh"

module qpu_exu_decode
  import qpu_exu_pkg::*;
(
  input  logic [`QPU_INSTR_SIZE-1:0] i_instr,
  output dec_info_t                 o_dec
);

  ////////////////////////////////////////////////////////////////////////////
  // Instruction fields

  op_e                         op;
  logic [`QPU_RFIDX_WIDTH-1:0] rd;
  logic [`QPU_RFIDX_WIDTH-1:0] rs1;
  logic [`QPU_RFIDX_WIDTH-1:0] rs2;
  logic [15:0]                 imm16;
  logic [`QPU_XLEN-1:0]        imm_sext;
  logic [`QPU_XLEN-1:0]        imm_zext;

  assign op    = op_e'(i_instr[31:28]);
  assign rd    = i_instr[27:24];
  assign rs1   = i_instr[23:20];
  assign rs2   = i_instr[19:16];
  assign imm16 = i_instr[15:0];

  assign imm_sext = {{(`QPU_XLEN-16){imm16[15]}}, imm16};
  assign imm_zext = {{(`QPU_XLEN-16){1'b0}}, imm16};

  ////////////////////////////////////////////////////////////////////////////
  // Opcode class and immediate select

  always_comb begin
    o_dec          = '0;
    o_dec.op       = op;
    o_dec.rd       = rd;
    o_dec.rs1      = rs1;
    o_dec.rs2      = rs2;
    o_dec.imm      = imm_zext;  // Quantum ops take it unsigned

    case (op)
      OP_ADD, OP_SUB: begin
        o_dec.is_alu = 1'b1;
      end
      OP_ADDI: begin
        o_dec.is_alu = 1'b1;
        o_dec.imm    = imm_sext;
      end
      OP_QWAIT: begin
        o_dec.is_qwait = 1'b1;
      end
      OP_QEVT: begin
        o_dec.is_qevt = 1'b1;
      end
      default: begin
        // Unknown opcode decodes to a no-op
      end
    endcase
  end

endmodule

// File: src/qpu_exu_regfile.sv
`timescale 1ns/100ps

`include "qpu_exu_defines.svh"

module qpu_exu_regfile
  import qpu_exu_pkg::*;
(
  input  logic                        clk,
  input  logic                        i_reset,

  // Read ports
  input  logic [`QPU_RFIDX_WIDTH-1:0] i_rs1_idx,
  input  logic [`QPU_RFIDX_WIDTH-1:0] i_rs2_idx,
  output logic [`QPU_XLEN-1:0]        o_rs1_data,
  output logic [`QPU_XLEN-1:0]        o_rs2_data,

  // Write port
  input  logic                        i_rd_wen,
  input  logic [`QPU_RFIDX_WIDTH-1:0] i_rd_idx,
  input  logic [`QPU_XLEN-1:0]        i_rd_data,

  // Time register
  input  logic                        i_time_wen,
  input  time_t                       i_time_data,
  output time_t                       o_time
);

  localparam int NREGS = 1 << `QPU_RFIDX_WIDTH;

  logic [`QPU_XLEN-1:0] regs [NREGS];
  time_t                time_q;

  ////////////////////////////////////////////////////////////////////////////
  // Classical registers

  always_ff @(posedge clk) begin
    if (i_reset) begin
      for (int i = 0; i < NREGS; i++) begin
        regs[i] <= '0;
      end
    end else if (i_rd_wen) begin
      regs[i_rd_idx] <= i_rd_data;  // Exec never writes x0
    end
  end

  assign o_rs1_data = (i_rs1_idx == '0) ? '0 : regs[i_rs1_idx];
  assign o_rs2_data = (i_rs2_idx == '0) ? '0 : regs[i_rs2_idx];

  // Current time point
  always_ff @(posedge clk) begin
    if (i_reset) begin
      time_q <= '0;
    end else if (i_time_wen) begin
      time_q <= i_time_data;
    end
  end

  assign o_time = time_q;

endmodule

// File: src/qpu_exu_exec.sv
`timescale 1ns/100ps

`include "qpu_exu_defines.svh"

module qpu_exu_exec
  import qpu_exu_pkg::*;
(
  // Instruction handshake
  input  logic                        i_valid,
  output logic                        o_ready,
  input  dec_info_t                   i_dec,

  // Operands
  input  logic [`QPU_XLEN-1:0]        i_rs1_data,
  input  logic [`QPU_XLEN-1:0]        i_rs2_data,
  input  time_t                       i_time,

  // Queue status
  input  logic                        i_tiq_full,
  input  logic                        i_evq_full,

  // Register file write back
  output logic                        o_rd_wen,
  output logic [`QPU_XLEN-1:0]        o_rd_data,
  output logic                        o_time_wen,
  output time_t                       o_time_data,

  // Queue pushes
  output logic                        o_tiq_push,
  output time_t                       o_tiq_data,
  output logic                        o_evq_push,
  output event_t                      o_evq_data
);

  logic                 accept;
  logic [`QPU_XLEN-1:0] alu_res;
  time_t                next_time;
  logic                 rd_nz;

  ////////////////////////////////////////////////////////////////////////////
  // Issue

  // Stall only a quantum op whose queue has no room
  assign o_ready = ~((i_dec.is_qwait & i_tiq_full) | (i_dec.is_qevt & i_evq_full));
  assign accept  = i_valid & o_ready;

  ////////////////////////////////////////////////////////////////////////////
  // Classical ALU

  always_comb begin
    case (i_dec.op)
      OP_ADD:  alu_res = i_rs1_data + i_rs2_data;
      OP_SUB:  alu_res = i_rs1_data - i_rs2_data;
      OP_ADDI: alu_res = i_rs1_data + i_dec.imm;
      default: alu_res = '0;
    endcase
  end

  assign rd_nz     = (i_dec.rd != '0);
  assign o_rd_wen  = accept & i_dec.is_alu & rd_nz;  // x0 stays zero
  assign o_rd_data = alu_res;

  ////////////////////////////////////////////////////////////////////////////
  // Time advance and event packing

  // Immediate is zero extended for QWAIT
  assign next_time = i_time + time_t'(i_dec.imm[`QPU_TIME_WIDTH-1:0]);

  assign o_time_wen  = accept & i_dec.is_qwait;
  assign o_time_data = next_time;

  assign o_tiq_push  = accept & i_dec.is_qwait;  // New time point to the queue
  assign o_tiq_data  = next_time;

  assign o_evq_push      = accept & i_dec.is_qevt;
  assign o_evq_data.mask = i_dec.imm[`QPU_EVENT_NUM-1:0];
  assign o_evq_data.data = i_rs1_data[`QPU_EVENT_WIRE_WIDTH-1:0];

endmodule

// File: src/qpu_exu_fifo.sv
`timescale 1ns/100ps

`include "qpu_exu_defines.svh"

module qpu_exu_fifo #(
  parameter type T_DATA = logic [7:0],
  parameter int  DEPTH  = `QPU_QUEUE_DEPTH
) (
  input  logic  clk,
  input  logic  i_reset,
  input  logic  i_push,
  input  T_DATA i_data,
  input  logic  i_pop,
  output T_DATA o_data,   // Head entry
  output logic  o_empty,
  output logic  o_full
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  T_DATA            mem [DEPTH];
  logic [PTR_W-1:0] rd_ptr;
  logic [PTR_W-1:0] wr_ptr;
  logic [CNT_W-1:0] count;
  logic             wr_en;
  logic             rd_en;

  function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
    return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign rd_en = i_pop & ~o_empty;
  assign wr_en = i_push & (~o_full | rd_en);

  always_ff @(posedge clk) begin
    if (i_reset) begin
      rd_ptr <= '0;
      wr_ptr <= '0;
      count  <= '0;
    end else begin
      if (wr_en) wr_ptr <= ptr_inc(wr_ptr);
      if (rd_en) rd_ptr <= ptr_inc(rd_ptr);
      case ({wr_en, rd_en})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;  // Idle or push with pop
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (wr_en) mem[wr_ptr] <= i_data;
  end

  assign o_data  = mem[rd_ptr];
  assign o_empty = (count == '0);
  assign o_full  = (count == CNT_W'(DEPTH));

endmodule

// File: src/qpu_exu_queue.sv
`timescale 1ns/100ps

`include "qpu_exu_defines.svh"

module qpu_exu_queue
  import qpu_exu_pkg::*;
(
  input  logic   clk,
  input  logic   i_reset,

  // Pushes from exec
  input  logic   i_tiq_push,
  input  time_t  i_tiq_data,
  input  logic   i_evq_push,
  input  event_t i_evq_data,

  // External trigger clock
  input  time_t  i_trig_clk,

  output logic   o_tiq_full,
  output logic   o_evq_full,

  // Trigger outputs
  output logic   o_trig_clk_ena,
  output logic   o_event_valid,
  output event_t o_event,

  output logic   o_busy
);

  time_t  tiq_head;
  event_t evq_head;
  logic   tiq_empty;
  logic   evq_empty;
  logic   release_evt;

  ////////////////////////////////////////////////////////////////////////////
  // Timing queue and event queue

  qpu_exu_fifo #(
    .T_DATA (time_t),
    .DEPTH  (`QPU_QUEUE_DEPTH)
  ) u_tiq (
    .clk     (clk),
    .i_reset (i_reset),
    .i_push  (i_tiq_push),
    .i_data  (i_tiq_data),
    .i_pop   (release_evt),
    .o_data  (tiq_head),
    .o_empty (tiq_empty),
    .o_full  (o_tiq_full)
  );

  qpu_exu_fifo #(
    .T_DATA (event_t),
    .DEPTH  (`QPU_QUEUE_DEPTH)
  ) u_evq (
    .clk     (clk),
    .i_reset (i_reset),
    .i_push  (i_evq_push),
    .i_data  (i_evq_data),
    .i_pop   (release_evt),
    .o_data  (evq_head),
    .o_empty (evq_empty),
    .o_full  (o_evq_full)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Release

  // Time point reached and an event paired with it
  assign release_evt = ~tiq_empty & ~evq_empty & (tiq_head <= i_trig_clk);

  always_ff @(posedge clk) begin
    if (i_reset) begin
      o_event_valid <= 1'b0;
    end else begin
      o_event_valid <= release_evt;  // One cycle pulse per event
    end
  end

  always_ff @(posedge clk) begin
    if (release_evt) o_event <= evq_head;
  end

  assign o_trig_clk_ena = ~tiq_empty;  // Time points pending
  assign o_busy         = ~tiq_empty | ~evq_empty;

endmodule

// File: src/qpu_exu.sv
`timescale 1ns/100ps

`include "qpu_exu_defines.svh"

module qpu_exu
  import qpu_exu_pkg::*;
(
  input  logic                       clk,
  input  logic                       i_reset,

  // Instruction input
  input  logic                       i_valid,
  output logic                       o_ready,
  input  logic [`QPU_INSTR_SIZE-1:0] i_instr,

  // Trigger side
  input  time_t                      i_trig_clk,
  output logic                       o_trig_clk_ena,
  output logic                       o_event_valid,
  output event_t                     o_event,

  output logic                       o_active
);

  dec_info_t            dec;
  logic [`QPU_XLEN-1:0] rs1_data;
  logic [`QPU_XLEN-1:0] rs2_data;
  time_t                cur_time;

  logic                 rd_wen;
  logic [`QPU_XLEN-1:0] rd_data;
  logic                 time_wen;
  time_t                time_data;

  logic                 tiq_push;
  time_t                tiq_data;
  logic                 evq_push;
  event_t               evq_data;
  logic                 tiq_full;
  logic                 evq_full;
  logic                 q_busy;

  ////////////////////////////////////////////////////////////////////////////
  // Decode and register file

  qpu_exu_decode u_decode (
    .i_instr (i_instr),
    .o_dec   (dec)
  );

  qpu_exu_regfile u_regfile (
    .clk         (clk),
    .i_reset     (i_reset),
    .i_rs1_idx   (dec.rs1),
    .i_rs2_idx   (dec.rs2),
    .o_rs1_data  (rs1_data),
    .o_rs2_data  (rs2_data),
    .i_rd_wen    (rd_wen),
    .i_rd_idx    (dec.rd),
    .i_rd_data   (rd_data),
    .i_time_wen  (time_wen),
    .i_time_data (time_data),
    .o_time      (cur_time)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Execute and queues

  qpu_exu_exec u_exec (
    .i_valid     (i_valid),
    .o_ready     (o_ready),
    .i_dec       (dec),
    .i_rs1_data  (rs1_data),
    .i_rs2_data  (rs2_data),
    .i_time      (cur_time),
    .i_tiq_full  (tiq_full),
    .i_evq_full  (evq_full),
    .o_rd_wen    (rd_wen),
    .o_rd_data   (rd_data),
    .o_time_wen  (time_wen),
    .o_time_data (time_data),
    .o_tiq_push  (tiq_push),
    .o_tiq_data  (tiq_data),
    .o_evq_push  (evq_push),
    .o_evq_data  (evq_data)
  );

  qpu_exu_queue u_queue (
    .clk            (clk),
    .i_reset        (i_reset),
    .i_tiq_push     (tiq_push),
    .i_tiq_data     (tiq_data),
    .i_evq_push     (evq_push),
    .i_evq_data     (evq_data),
    .i_trig_clk     (i_trig_clk),
    .o_tiq_full     (tiq_full),
    .o_evq_full     (evq_full),
    .o_trig_clk_ena (o_trig_clk_ena),
    .o_event_valid  (o_event_valid),
    .o_event        (o_event),
    .o_busy         (q_busy)
  );

  assign o_active = q_busy | i_valid;  // Work queued or an instruction waiting

endmodule

// File: dv/qpu_exu_tb_tests.svh
////////////////////////////////////////////////////////////////////////////
// Directed tests entered 1 ns after a rising edge

task automatic check_after_reset();
  test_name = "reset";
  check_val("o_event_valid", 0, o_event_valid);
  check_val("o_trig_clk_ena", 0, o_trig_clk_ena);
  check_val("o_active", 0, o_active);
  check_val("o_ready", 1, o_ready);
endtask

task automatic run_arith();
  test_name  = "arith";
  i_trig_clk = '1;
  issue(encode(OP_ADDI, 1, 0, 0, 16'd100));
  issue(encode(OP_ADDI, 2, 0, 0, 16'hFFF9));  // -7
  issue(encode(OP_ADD, 3, 1, 2, 16'd0));
  issue(encode(OP_SUB, 4, 2, 1, 16'd0));
  issue(encode(OP_ADDI, 6, 2, 0, 16'h8000));  // Most negative immediate
  issue(encode(OP_ADDI, 0, 1, 0, 16'd5));
  issue(encode(OP_ADD, 0, 1, 1, 16'd0));
  for (int r = 0; r < 7; r++) read_reg(r[3:0]);
  drain();
endtask

task automatic check_time_order();
  time_t t0;
  int    start;
  test_name  = "time_order";
  t0         = mtime;
  i_trig_clk = '0;
  issue(encode(OP_QWAIT, 0, 0, 0, 16'd10));
  issue(encode(OP_QEVT, 0, 1, 0, 16'h00A1));  // Event A
  issue(encode(OP_QWAIT, 0, 0, 0, 16'd5));
  issue(encode(OP_QEVT, 0, 2, 0, 16'h00B2));  // Event B
  start = rel_cnt;
  check_val("o_trig_clk_ena", 1, o_trig_clk_ena);
  i_trig_clk = t0 + 16'd9;
  repeat (5) @(posedge clk);
  #1;
  check_val("events before first time point", start, rel_cnt);
  i_trig_clk = t0 + 16'd10;
  wait_events(start + 1);
  repeat (3) @(posedge clk);
  #1 i_trig_clk = t0 + 16'd14;
  repeat (5) @(posedge clk);
  #1;
  check_val("events before second time point", start + 1, rel_cnt);
  check_val("o_trig_clk_ena", 1, o_trig_clk_ena);
  i_trig_clk = t0 + 16'd15;
  wait_events(start + 2);
  drain();
  check_val("o_trig_clk_ena", 0, o_trig_clk_ena);
endtask

task automatic fill_queues();
  test_name  = "back_pressure";
  i_trig_clk = '0;
  repeat (4) issue(encode(OP_QWAIT, 0, 0, 0, 16'd1));
  probe_ready(encode(OP_QWAIT, 0, 0, 0, 16'd1), 0);
  for (int r = 1; r <= 4; r++) issue(encode(OP_QEVT, 0, r[3:0], 0, 16'h0040));
  probe_ready(encode(OP_QEVT, 0, 5, 0, 16'h0041), 0);
  probe_ready(encode(OP_ADD, 5, 1, 2, 16'd0), 1);
  issue(encode(OP_ADD, 5, 1, 2, 16'd0));
  fork
    begin
      issue(encode(OP_QWAIT, 0, 0, 0, 16'd1));
      issue(encode(OP_QEVT, 0, 5, 0, 16'h0041));  // Carries the ADD result
    end
    begin
      repeat (3) @(posedge clk);
      #1 i_trig_clk = '1;
    end
  join
  drain();
endtask

task automatic run_illegal_op();
  int start;
  test_name  = "illegal_op";
  i_trig_clk = '1;
  start      = rel_cnt;
  issue(encode(4'hF, 1, 2, 3, 16'h1234));
  issue(encode(4'h0, 2, 1, 1, 16'h0001));
  repeat (3) @(posedge clk);
  #1;
  check_val("events after illegal op", start, rel_cnt);
  for (int r = 0; r < 16; r++) read_reg(r[3:0]);
  drain();
endtask

task automatic run_random_mix();
  logic [3:0] op;
  logic [3:0] rd;
  test_name  = "random_mix";
  i_trig_clk = '1;
  for (int n = 0; n < 40; n++) begin
    op = 4'($urandom_range(3, 1));  // ADD, SUB or ADDI
    rd = 4'($urandom);
    issue(encode(op, rd, 4'($urandom), 4'($urandom), 16'($urandom)));
    issue(encode(OP_QWAIT, 0, 0, 0, 16'd0));
    issue(encode(OP_QEVT, 0, rd, 0, 16'($urandom)));
  end
  #2;
  check_val("o_active with events queued", 1, o_active);
  drain();
endtask

// File: dv/qpu_exu_tb.sv
`timescale 1ns/100ps

`include "qpu_exu_defines.svh"

module qpu_exu_tb
  import qpu_exu_pkg::*;
();

  // About sixteen times what the whole test sequence needs
  localparam int MAX_CYCLES = 4000;

  logic                       clk = 1'b0;
  logic                       i_reset;
  logic                       i_valid;
  logic [`QPU_INSTR_SIZE-1:0] i_instr;
  time_t                      i_trig_clk;
  logic                       o_ready;
  logic                       o_trig_clk_ena;
  logic                       o_event_valid;
  event_t                     o_event;
  logic                       o_active;

  // Reference model state
  logic [`QPU_XLEN-1:0] mregs [16];
  time_t                mtime;
  event_t               exp_q [$];

  string test_name = "none";
  int    errors    = 0;
  int    checks    = 0;
  int    rel_cnt   = 0;  // Events seen on the trigger outputs
  int    cycles    = 0;

  always #5 clk = ~clk;

  qpu_exu qpu_exu_i (.*);

  always @(posedge clk) begin
    cycles++;
    if (cycles >= MAX_CYCLES) begin
      $display("Timeout after %0d cycles, the DUT stopped making progress", cycles);
      $display("RESULT: FAIL");
      $finish;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Event monitor sampled mid cycle

  always @(negedge clk) begin
    event_t want;
    if (!i_reset && o_event_valid) begin
      rel_cnt++;
      if (exp_q.size() == 0) begin
        errors++;
        $display("Event %h released in test %s with none expected", o_event, test_name);
      end else begin
        want = exp_q.pop_front();
        checks++;
        assert (o_event == want) else begin
          errors++;
          $display("Fail %s expected %h actual %h", test_name, want, o_event);
        end
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Model and drivers

  function automatic logic [31:0] encode(input logic [3:0] op, input logic [3:0] rd,
                                         input logic [3:0] rs1, input logic [3:0] rs2,
                                         input logic [15:0] imm);
    return {op, rd, rs1, rs2, imm};
  endfunction

  // Architectural effect of one accepted instruction
  task automatic model_exec(input logic [31:0] instr);
    logic [3:0]  op;
    logic [3:0]  rd;
    logic [3:0]  rs1;
    logic [3:0]  rs2;
    logic [15:0] imm;
    event_t      ev;
    op  = instr[31:28];
    rd  = instr[27:24];
    rs1 = instr[23:20];
    rs2 = instr[19:16];
    imm = instr[15:0];
    case (op)
      4'd1: if (rd != 0) mregs[rd] = mregs[rs1] + mregs[rs2];  // ADD
      4'd2: if (rd != 0) mregs[rd] = mregs[rs1] - mregs[rs2];  // SUB
      4'd3: if (rd != 0) mregs[rd] = mregs[rs1] + {{16{imm[15]}}, imm};
      4'd4: mtime = mtime + imm;  // QWAIT with an unsigned step
      4'd5: begin
        ev.mask = imm[7:0];
        ev.data = mregs[rs1][15:0];
        exp_q.push_back(ev);
      end
      default: ;
    endcase
  endtask

  // Holds the instruction until the DUT takes it
  task automatic issue(input logic [31:0] instr);
    logic took;
    took    = 1'b0;
    i_valid = 1'b1;
    i_instr = instr;
    while (!took) begin
      #2 took = o_ready;
      @(posedge clk);
      #1;
    end
    i_valid = 1'b0;
    model_exec(instr);
  endtask

  task automatic check_val(input string what, input int exp, input int act);
    checks++;
    assert (exp == act) else begin
      errors++;
      $display("Fail %s %s expected %0d actual %0d", test_name, what, exp, act);
    end
  endtask

  // Shows an instruction with i_valid low for one cycle, so it is never taken
  task automatic probe_ready(input logic [31:0] instr, input int exp);
    i_instr = instr;
    @(negedge clk);
    check_val("o_ready", exp, o_ready);
    @(posedge clk);
    #1;
  endtask

  task automatic read_reg(input logic [3:0] r);
    issue(encode(OP_QWAIT, 0, 0, 0, 16'd0));
    issue(encode(OP_QEVT, 0, r, 0, {12'h0, r}));  // Mask tags the register
  endtask

  task automatic wait_events(input int target);
    while (rel_cnt < target) begin
      @(posedge clk);
      #1;
    end
  endtask

  task automatic drain();
    while (o_active) begin
      @(posedge clk);
      #1;
    end
    @(posedge clk);
    #1;
    check_val("events still expected", 0, exp_q.size());
  endtask

  `include "qpu_exu_tb_tests.svh"

  initial begin
    void'($urandom(33));
    i_reset    = 1'b1;
    i_valid    = 1'b0;
    i_instr    = '0;
    i_trig_clk = '0;
    mtime      = '0;
    foreach (mregs[i]) mregs[i] = '0;
    repeat (10) @(posedge clk);
    #1 i_reset = 1'b0;
    check_after_reset();
    run_arith();
    check_time_order();
    fill_queues();
    run_illegal_op();
    run_random_mix();
    $display("Checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

// File: qpu_exu.f
+incdir+src
+incdir+dv
src/qpu_exu_pkg.sv
src/qpu_exu_decode.sv
src/qpu_exu_regfile.sv
src/qpu_exu_exec.sv
src/qpu_exu_fifo.sv
src/qpu_exu_queue.sv
src/qpu_exu.sv
dv/qpu_exu_tb.sv

// File: Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal \
	  --top-module qpu_exu_tb -f qpu_exu.f -o qpu_exu_sim
	./obj_dir/qpu_exu_sim > sim.log 2>&1
	@cat sim.log
	@if grep -q "RESULT: FAIL" sim.log; then exit 1; fi

clean:
	rm -rf obj_dir sim.log
